//--- build.f
common/mips_pkg.sv
pipeline/instruction_fetch.sv
pipeline/instruction_decode.sv
pipeline/execution.sv
pipeline/shortcircuit_unit.sv
debug/host_interface.sv
debug/debug_latch_reader.sv
debug/debug_regfile_reader.sv
hdl/pipeline_top.sv
sim/tb_pipeline_top.sv

//--- common/mips_pkg.sv
package mips_pkg;

   localparam int NB_REG        = 32;
   localparam int NB_INSTR      = 32;
   localparam int NB_REG_ADDR   = 5;
   localparam int REGFILE_DEPTH = 32;
   localparam int NB_INSTR_ADDR = 6;
   localparam int NB_FRAME      = 32;
   localparam int NB_CMD        = 6;
   localparam int NB_OPCODE     = 6;
   localparam int NB_IMM        = 16;

   // Host commands, top field of a frame
   localparam logic [NB_CMD-1:0] CMD_IDLE       = 6'h00;
   localparam logic [NB_CMD-1:0] CMD_INSTR_LOW  = 6'h01;
   localparam logic [NB_CMD-1:0] CMD_INSTR_HIGH = 6'h02;
   localparam logic [NB_CMD-1:0] CMD_RUN        = 6'h03;
   localparam logic [NB_CMD-1:0] CMD_SOFT_RESET = 6'h04;
   localparam logic [NB_CMD-1:0] CMD_READ       = 6'h05;

   // Zero is the idle request, so no reader uses it
   localparam logic [NB_CMD-1:0] READER_FETCH_STATE = 6'h11;
   localparam logic [NB_CMD-1:0] READER_WB_STATE    = 6'h12;
   localparam logic [NB_CMD-1:0] READER_REGFILE     = 6'h13;

   localparam logic [NB_OPCODE-1:0] OP_RTYPE = 6'h00;
   localparam logic [NB_OPCODE-1:0] OP_ADDIU = 6'h09;
   localparam logic [NB_OPCODE-1:0] OP_ANDI  = 6'h0c;
   localparam logic [NB_OPCODE-1:0] OP_ORI   = 6'h0d;
   localparam logic [NB_OPCODE-1:0] OP_HALT  = 6'h3f;

   localparam logic [NB_OPCODE-1:0] FN_ADDU = 6'h21;
   localparam logic [NB_OPCODE-1:0] FN_SUBU = 6'h23;
   localparam logic [NB_OPCODE-1:0] FN_AND  = 6'h24;
   localparam logic [NB_OPCODE-1:0] FN_OR   = 6'h25;
   localparam logic [NB_OPCODE-1:0] FN_XOR  = 6'h26;
   localparam logic [NB_OPCODE-1:0] FN_SLT  = 6'h2a;

   // Field MSB positions inside an instruction
   localparam int MSB_OPCODE = 31;
   localparam int MSB_RS     = 25;
   localparam int MSB_RT     = 20;
   localparam int MSB_RD     = 15;
   localparam int MSB_IMM    = 15;
   localparam int MSB_FUNC   = 5;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT
   } alu_op_t;

   typedef struct packed {
      logic [NB_REG-1:0]   addr;
      logic [NB_INSTR-1:0] instr;
   } fetch_snapshot_t;

   typedef struct packed {
      logic                   we;
      logic [NB_REG_ADDR-1:0] dest;
      logic [NB_REG-1:0]      data;
   } wb_snapshot_t;

endpackage

//--- debug/debug_latch_reader.sv
`timescale 1ns/10ps

module debug_latch_reader import mips_pkg::*; #(
   parameter type               T_PAYLOAD = fetch_snapshot_t,
   parameter logic [NB_CMD-1:0] READER_ID = READER_FETCH_STATE
) (
   input  logic                i_clock,
   input  logic                i_reset,
   input  logic [NB_CMD-1:0]   i_request_select,
   input  T_PAYLOAD            i_payload,
   output logic [NB_FRAME-1:0] o_frame,
   output logic                o_writing
);

   localparam int NB_PAYLOAD = $bits(T_PAYLOAD);
   localparam int N_FRAMES   = (NB_PAYLOAD + NB_FRAME - 1) / NB_FRAME;
   localparam int NB_WIDE    = N_FRAMES * NB_FRAME;
   localparam int NB_COUNT   = $clog2(N_FRAMES + 1);

   logic [NB_WIDE-1:0]  shift;
   logic [NB_COUNT-1:0] remaining;
   logic                start;

   assign start = (remaining == '0) && (i_request_select == READER_ID);

   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         remaining <= '0;
      end else if (start) begin
         remaining <= NB_COUNT'(N_FRAMES);
      end else if (remaining != '0) begin
         remaining <= remaining - 1'b1;
      end
   end

   // Low word goes out first
   always_ff @(posedge i_clock) begin
      if (start) begin
         shift <= NB_WIDE'(i_payload);
      end else if (o_writing) begin
         shift <= shift >> NB_FRAME;
      end
   end

   assign o_frame   = shift[NB_FRAME-1:0];
   assign o_writing = (remaining != '0);

endmodule

//--- debug/debug_regfile_reader.sv
`timescale 1ns/10ps

module debug_regfile_reader import mips_pkg::*; (
   input  logic                   i_clock,
   input  logic                   i_reset,
   input  logic [NB_CMD-1:0]      i_request_select,
   input  logic [NB_REG-1:0]      i_reg_data,
   output logic [NB_REG_ADDR-1:0] o_reg_addr,
   output logic [NB_FRAME-1:0]    o_frame,
   output logic                   o_writing
);

   logic last;

   assign last = (o_reg_addr == NB_REG_ADDR'(REGFILE_DEPTH - 1));

   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         o_reg_addr <= '0;
         o_writing  <= 1'b0;
      end else if (!o_writing) begin
         o_reg_addr <= '0;
         o_writing  <= (i_request_select == READER_REGFILE);
      end else begin
         o_reg_addr <= o_reg_addr + 1'b1;
         if (last) begin
            o_writing <= 1'b0;
         end
      end
   end

   // One register per frame, read combinationally
   assign o_frame = i_reg_data;

   a_no_wrap: assert property (@(posedge i_clock) disable iff (i_reset)
      (o_writing && last) |=> !o_writing);

endmodule

//--- debug/host_interface.sv
`timescale 1ns/10ps

module host_interface import mips_pkg::*; (
   input  logic                     i_clock,
   input  logic                     i_reset,
   input  logic [NB_FRAME-1:0]      i_frame_from_host,
   input  logic [NB_FRAME-1:0]      i_fetch_frame,
   input  logic [NB_FRAME-1:0]      i_wb_frame,
   input  logic [NB_FRAME-1:0]      i_regfile_frame,
   input  logic                     i_fetch_writing,
   input  logic                     i_wb_writing,
   input  logic                     i_regfile_writing,
   output logic                     o_instr_we,
   output logic [NB_INSTR_ADDR-1:0] o_instr_addr,
   output logic [NB_INSTR-1:0]      o_instr_data,
   output logic                     o_run,
   output logic                     o_core_reset,
   output logic [NB_CMD-1:0]        o_request_select,
   output logic [NB_FRAME-1:0]      o_frame_to_host,
   output logic                     o_frame_valid,
   output logic                     o_end_of_data
);

   localparam int NB_HALF = NB_INSTR / 2;

   logic [NB_CMD-1:0]  cmd;
   logic [NB_HALF-1:0] low_half;
   logic [2:0]         writing;
   logic               writing_d;
   logic               busy;

   assign cmd     = i_frame_from_host[NB_FRAME-1 -: NB_CMD];
   assign writing = {i_fetch_writing, i_wb_writing, i_regfile_writing};
   assign busy    = (|writing) || (o_request_select != '0);

   // Upper half carries the word address in bits 21:16
   assign o_instr_we   = (cmd == CMD_INSTR_HIGH);
   assign o_instr_addr = i_frame_from_host[NB_HALF +: NB_INSTR_ADDR];
   assign o_instr_data = {i_frame_from_host[NB_HALF-1:0], low_half};
   assign o_core_reset = i_reset | (cmd == CMD_SOFT_RESET);

   always_ff @(posedge i_clock) begin
      if (cmd == CMD_INSTR_LOW) begin
         low_half <= i_frame_from_host[NB_HALF-1:0];
      end
   end

   always_ff @(posedge i_clock) begin
      if (i_reset || cmd == CMD_SOFT_RESET) begin
         o_run <= 1'b0;
      end else if (cmd == CMD_RUN) begin
         o_run <= 1'b1;
      end
   end

   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         o_request_select <= '0;
         writing_d        <= 1'b0;
      end else begin
         o_request_select <= (cmd == CMD_READ && !busy) ? i_frame_from_host[NB_CMD-1:0] : '0;
         writing_d        <= |writing;
      end
   end

   always_comb begin
      case (writing)
         3'b100:  o_frame_to_host = i_fetch_frame;
         3'b010:  o_frame_to_host = i_wb_frame;
         3'b001:  o_frame_to_host = i_regfile_frame;
         default: o_frame_to_host = '0;
      endcase
   end

   assign o_frame_valid = |writing;
   assign o_end_of_data = writing_d & ~(|writing);

   a_one_reader: assert property (@(posedge i_clock) disable iff (i_reset)
      $onehot0(writing));

endmodule

//--- hdl/pipeline_top.sv
`timescale 1ns/10ps

module pipeline_top import mips_pkg::*; (
   input  logic                i_clock,
   input  logic                i_reset,
   input  logic [NB_FRAME-1:0] i_frame_from_host,
   output logic [NB_FRAME-1:0] o_frame_to_host,
   output logic                o_frame_valid,
   output logic                o_end_of_data,
   output logic                o_halted
);

   // Host side
   logic                     instr_we;
   logic [NB_INSTR_ADDR-1:0] instr_addr;
   logic [NB_INSTR-1:0]      instr_data;
   logic                     run;
   logic                     core_reset;
   logic [NB_CMD-1:0]        request_select;

   // Fetch to decode
   logic [NB_INSTR-1:0]      if_ir;
   logic [NB_INSTR_ADDR-1:0] if_ir_addr;

   // Decode to execution
   logic [NB_REG-1:0]        id_a;
   logic [NB_REG-1:0]        id_b;
   logic [NB_REG-1:0]        id_imm;
   logic                     id_use_imm;
   alu_op_t                  id_alu_op;
   logic [NB_REG_ADDR-1:0]   id_dest;
   logic                     id_we;
   logic [NB_REG_ADDR-1:0]   id_rs;
   logic [NB_REG_ADDR-1:0]   id_rt;

   // Writeback and forwarding
   logic [NB_REG-1:0]        wb_data;
   logic [NB_REG_ADDR-1:0]   wb_dest;
   logic                     wb_we;
   logic                     fwd_a;
   logic                     fwd_b;

   // Debug readers
   fetch_snapshot_t          fetch_state;
   wb_snapshot_t             wb_state;
   logic [NB_REG_ADDR-1:0]   debug_reg_addr;
   logic [NB_REG-1:0]        debug_reg_data;
   logic [NB_FRAME-1:0]      fetch_frame;
   logic [NB_FRAME-1:0]      wb_frame;
   logic [NB_FRAME-1:0]      regfile_frame;
   logic                     fetch_writing;
   logic                     wb_writing;
   logic                     regfile_writing;

   instruction_fetch u_instruction_fetch (
      .i_clock      (i_clock),
      .i_reset      (core_reset),
      .i_run        (run),
      .i_halt       (o_halted),
      .i_instr_we   (instr_we),
      .i_instr_addr (instr_addr),
      .i_instr_data (instr_data),
      .o_ir         (if_ir),
      .o_ir_addr    (if_ir_addr)
   );

   instruction_decode u_instruction_decode (
      .i_clock          (i_clock),
      .i_reset          (core_reset),
      .i_run            (run),
      .i_ir             (if_ir),
      .i_ir_addr        (if_ir_addr),
      .i_wb_we          (wb_we),
      .i_wb_dest        (wb_dest),
      .i_wb_data        (wb_data),
      .i_debug_reg_addr (debug_reg_addr),
      .o_halt           (o_halted),
      .o_a              (id_a),
      .o_b              (id_b),
      .o_imm            (id_imm),
      .o_use_imm        (id_use_imm),
      .o_alu_op         (id_alu_op),
      .o_dest           (id_dest),
      .o_we             (id_we),
      .o_rs             (id_rs),
      .o_rt             (id_rt),
      .o_debug_reg_data (debug_reg_data),
      .o_fetch_state    (fetch_state)
   );

   execution u_execution (
      .i_clock    (i_clock),
      .i_reset    (core_reset),
      .i_a        (id_a),
      .i_b        (id_b),
      .i_imm      (id_imm),
      .i_use_imm  (id_use_imm),
      .i_alu_op   (id_alu_op),
      .i_dest     (id_dest),
      .i_we       (id_we),
      .i_fwd_a    (fwd_a),
      .i_fwd_b    (fwd_b),
      .o_wb_data  (wb_data),
      .o_wb_dest  (wb_dest),
      .o_wb_we    (wb_we),
      .o_wb_state (wb_state)
   );

   shortcircuit_unit u_shortcircuit_unit (
      .i_rs      (id_rs),
      .i_rt      (id_rt),
      .i_wb_dest (wb_dest),
      .i_wb_we   (wb_we),
      .o_fwd_a   (fwd_a),
      .o_fwd_b   (fwd_b)
   );

   host_interface u_host_interface (
      .i_clock           (i_clock),
      .i_reset           (i_reset),
      .i_frame_from_host (i_frame_from_host),
      .i_fetch_frame     (fetch_frame),
      .i_wb_frame        (wb_frame),
      .i_regfile_frame   (regfile_frame),
      .i_fetch_writing   (fetch_writing),
      .i_wb_writing      (wb_writing),
      .i_regfile_writing (regfile_writing),
      .o_instr_we        (instr_we),
      .o_instr_addr      (instr_addr),
      .o_instr_data      (instr_data),
      .o_run             (run),
      .o_core_reset      (core_reset),
      .o_request_select  (request_select),
      .o_frame_to_host   (o_frame_to_host),
      .o_frame_valid     (o_frame_valid),
      .o_end_of_data     (o_end_of_data)
   );

   debug_latch_reader #(
      .T_PAYLOAD (fetch_snapshot_t),
      .READER_ID (READER_FETCH_STATE)
   ) u_fetch_reader (
      .i_clock          (i_clock),
      .i_reset          (core_reset),
      .i_request_select (request_select),
      .i_payload        (fetch_state),
      .o_frame          (fetch_frame),
      .o_writing        (fetch_writing)
   );

   debug_latch_reader #(
      .T_PAYLOAD (wb_snapshot_t),
      .READER_ID (READER_WB_STATE)
   ) u_wb_reader (
      .i_clock          (i_clock),
      .i_reset          (core_reset),
      .i_request_select (request_select),
      .i_payload        (wb_state),
      .o_frame          (wb_frame),
      .o_writing        (wb_writing)
   );

   debug_regfile_reader u_regfile_reader (
      .i_clock          (i_clock),
      .i_reset          (core_reset),
      .i_request_select (request_select),
      .i_reg_data       (debug_reg_data),
      .o_reg_addr       (debug_reg_addr),
      .o_frame          (regfile_frame),
      .o_writing        (regfile_writing)
   );

endmodule

//--- pipeline/execution.sv
`timescale 1ns/10ps

module execution import mips_pkg::*; (
   input  logic                   i_clock,
   input  logic                   i_reset,
   input  logic [NB_REG-1:0]      i_a,
   input  logic [NB_REG-1:0]      i_b,
   input  logic [NB_REG-1:0]      i_imm,
   input  logic                   i_use_imm,
   input  alu_op_t                i_alu_op,
   input  logic [NB_REG_ADDR-1:0] i_dest,
   input  logic                   i_we,
   input  logic                   i_fwd_a,
   input  logic                   i_fwd_b,
   output logic [NB_REG-1:0]      o_wb_data,
   output logic [NB_REG_ADDR-1:0] o_wb_dest,
   output logic                   o_wb_we,
   output wb_snapshot_t           o_wb_state
);

   logic [NB_REG-1:0] op_a;
   logic [NB_REG-1:0] op_b_reg;
   logic [NB_REG-1:0] op_b;
   logic [NB_REG-1:0] alu_result;

   // Forward from the writeback register
   assign op_a     = i_fwd_a ? o_wb_data : i_a;
   assign op_b_reg = i_fwd_b ? o_wb_data : i_b;
   assign op_b     = i_use_imm ? i_imm : op_b_reg;

   always_comb begin
      case (i_alu_op)
         ALU_ADD: alu_result = op_a + op_b;
         ALU_SUB: alu_result = op_a - op_b;
         ALU_AND: alu_result = op_a & op_b;
         ALU_OR:  alu_result = op_a | op_b;
         ALU_XOR: alu_result = op_a ^ op_b;
         ALU_SLT: alu_result = {{(NB_REG-1){1'b0}}, $signed(op_a) < $signed(op_b)};
         default: alu_result = '0;
      endcase
   end

   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         o_wb_data <= '0;
         o_wb_dest <= '0;
         o_wb_we   <= 1'b0;
      end else begin
         o_wb_data <= alu_result;
         o_wb_dest <= i_dest;
         o_wb_we   <= i_we;
      end
   end

   assign o_wb_state.we   = o_wb_we;
   assign o_wb_state.dest = o_wb_dest;
   assign o_wb_state.data = o_wb_data;

endmodule

//--- pipeline/instruction_decode.sv
`timescale 1ns/10ps

module instruction_decode import mips_pkg::*; (
   input  logic                     i_clock,
   input  logic                     i_reset,
   input  logic                     i_run,
   input  logic [NB_INSTR-1:0]      i_ir,
   input  logic [NB_INSTR_ADDR-1:0] i_ir_addr,
   input  logic                     i_wb_we,
   input  logic [NB_REG_ADDR-1:0]   i_wb_dest,
   input  logic [NB_REG-1:0]        i_wb_data,
   input  logic [NB_REG_ADDR-1:0]   i_debug_reg_addr,
   output logic                     o_halt,
   output logic [NB_REG-1:0]        o_a,
   output logic [NB_REG-1:0]        o_b,
   output logic [NB_REG-1:0]        o_imm,
   output logic                     o_use_imm,
   output alu_op_t                  o_alu_op,
   output logic [NB_REG_ADDR-1:0]   o_dest,
   output logic                     o_we,
   output logic [NB_REG_ADDR-1:0]   o_rs,
   output logic [NB_REG_ADDR-1:0]   o_rt,
   output logic [NB_REG-1:0]        o_debug_reg_data,
   output fetch_snapshot_t          o_fetch_state
);

   logic [NB_REG-1:0]      regs [REGFILE_DEPTH];
   logic [NB_OPCODE-1:0]   opcode;
   logic [NB_OPCODE-1:0]   funct;
   logic [NB_REG_ADDR-1:0] rs;
   logic [NB_REG_ADDR-1:0] rt;
   logic [NB_REG_ADDR-1:0] rd;
   logic [NB_IMM-1:0]      imm;
   logic                   is_halt;
   logic                   issue;
   logic [NB_REG-1:0]      rd_a;
   logic [NB_REG-1:0]      rd_b;
   logic [NB_REG-1:0]      imm_ext;
   logic                   use_imm;
   logic                   we;
   alu_op_t                alu_op;
   logic [NB_REG_ADDR-1:0] dest;

   assign opcode  = i_ir[MSB_OPCODE -: NB_OPCODE];
   assign funct   = i_ir[MSB_FUNC -: NB_OPCODE];
   assign rs      = i_ir[MSB_RS -: NB_REG_ADDR];
   assign rt      = i_ir[MSB_RT -: NB_REG_ADDR];
   assign rd      = i_ir[MSB_RD -: NB_REG_ADDR];
   assign imm     = i_ir[MSB_IMM -: NB_IMM];
   assign is_halt = (opcode == OP_HALT);
   assign issue   = i_run & ~is_halt;

   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         for (int i = 0; i < REGFILE_DEPTH; i++) begin
            regs[i] <= '0;
         end
      end else if (i_wb_we && i_wb_dest != '0) begin
         regs[i_wb_dest] <= i_wb_data;
      end
   end

   // Write-through so a value written this cycle is read this cycle
   assign rd_a = (i_wb_we && i_wb_dest == rs && rs != '0) ? i_wb_data : regs[rs];
   assign rd_b = (i_wb_we && i_wb_dest == rt && rt != '0) ? i_wb_data : regs[rt];

   assign o_debug_reg_data    = regs[i_debug_reg_addr];
   assign o_fetch_state.addr  = NB_REG'(i_ir_addr);
   assign o_fetch_state.instr = i_ir;

   always_comb begin
      alu_op  = ALU_ADD;
      use_imm = 1'b0;
      dest    = rd;
      we      = 1'b0;
      imm_ext = {{(NB_REG-NB_IMM){imm[NB_IMM-1]}}, imm};
      case (opcode)
         OP_RTYPE: begin
            we = 1'b1;
            case (funct)
               FN_ADDU: alu_op = ALU_ADD;
               FN_SUBU: alu_op = ALU_SUB;
               FN_AND:  alu_op = ALU_AND;
               FN_OR:   alu_op = ALU_OR;
               FN_XOR:  alu_op = ALU_XOR;
               FN_SLT:  alu_op = ALU_SLT;
               default: we = 1'b0;
            endcase
         end
         OP_ADDIU: begin
            use_imm = 1'b1;
            dest    = rt;
            we      = 1'b1;
         end
         OP_ANDI, OP_ORI: begin
            alu_op  = (opcode == OP_ANDI) ? ALU_AND : ALU_OR;
            use_imm = 1'b1;
            dest    = rt;
            we      = 1'b1;
            imm_ext = {{(NB_REG-NB_IMM){1'b0}}, imm};
         end
         default: ;
      endcase
      if (dest == '0) begin
         we = 1'b0;
      end
   end

   // Decode/execute register, a bubble is all zeros
   always_ff @(posedge i_clock) begin
      if (i_reset || !issue) begin
         o_a       <= '0;
         o_b       <= '0;
         o_imm     <= '0;
         o_use_imm <= 1'b0;
         o_alu_op  <= ALU_ADD;
         o_dest    <= '0;
         o_we      <= 1'b0;
         o_rs      <= '0;
         o_rt      <= '0;
      end else begin
         o_a       <= rd_a;
         o_b       <= rd_b;
         o_imm     <= imm_ext;
         o_use_imm <= use_imm;
         o_alu_op  <= alu_op;
         o_dest    <= dest;
         o_we      <= we;
         o_rs      <= rs;
         o_rt      <= rt;
      end
   end

   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         o_halt <= 1'b0;
      end else if (i_run && is_halt) begin
         o_halt <= 1'b1;
      end
   end

   a_no_r0_write: assert property (@(posedge i_clock) disable iff (i_reset)
      o_we |-> o_dest != '0);

endmodule

//--- pipeline/instruction_fetch.sv
`timescale 1ns/10ps

module instruction_fetch import mips_pkg::*; (
   input  logic                     i_clock,
   input  logic                     i_reset,
   input  logic                     i_run,
   input  logic                     i_halt,
   input  logic                     i_instr_we,
   input  logic [NB_INSTR_ADDR-1:0] i_instr_addr,
   input  logic [NB_INSTR-1:0]      i_instr_data,
   output logic [NB_INSTR-1:0]      o_ir,
   output logic [NB_INSTR_ADDR-1:0] o_ir_addr
);

   logic [NB_INSTR-1:0]      imem [2**NB_INSTR_ADDR];
   logic [NB_INSTR_ADDR-1:0] pc;
   logic                     advance;

   // A HALT in the fetch/decode register stays put so decode keeps seeing it
   assign advance = i_run & ~i_halt & (o_ir[MSB_OPCODE -: NB_OPCODE] != OP_HALT);

   // Host write port
   always_ff @(posedge i_clock) begin
      if (i_instr_we) begin
         imem[i_instr_addr] <= i_instr_data;
      end
   end

   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         pc        <= '0;
         o_ir      <= '0;
         o_ir_addr <= '0;
      end else if (advance) begin
         o_ir      <= imem[pc];
         o_ir_addr <= pc;
         pc        <= pc + 1'b1;
      end
   end

endmodule

//--- pipeline/shortcircuit_unit.sv
`timescale 1ns/10ps

module shortcircuit_unit import mips_pkg::*; (
   input  logic [NB_REG_ADDR-1:0] i_rs,
   input  logic [NB_REG_ADDR-1:0] i_rt,
   input  logic [NB_REG_ADDR-1:0] i_wb_dest,
   input  logic                   i_wb_we,
   output logic                   o_fwd_a,
   output logic                   o_fwd_b
);

   // r0 always reads zero, never a forwarded value
   always_comb begin
      o_fwd_a = i_wb_we && (i_wb_dest == i_rs) && (i_rs != '0);
      o_fwd_b = i_wb_we && (i_wb_dest == i_rt) && (i_rt != '0);
   end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_pipeline_top -f build.f
output=$(./obj_dir/Vtb_pipeline_top)
echo "$output"
if grep -q 'All tests passed!' <<< "$output"; then
   exit 0
else
   exit 1
fi

//--- sim/tb_pipeline_top.sv
`timescale 1ns/10ps

module tb_pipeline_top import mips_pkg::*; ();

   localparam int PROG_LEN = 24;
   localparam logic [31:0] HALT_WORD = {OP_HALT, 26'b0};
   // Two loads of 25 words at 4 cycles, two runs and six readouts of up to
   // 34 frames each need about 520 cycles
   localparam int TIMEOUT_CYCLES = 2000;

   logic                i_clock;
   logic                reset;
   logic [NB_FRAME-1:0] frame_from_host;
   logic [NB_FRAME-1:0] frame_to_host;
   logic                frame_valid;
   logic                end_of_data;
   logic                halted;

   logic [31:0] rand_state = 32'haf4a;
   logic [31:0] model_regs [32];
   logic [31:0] frames [$];
   logic        valid_prev = 1'b0;
   int          eod_count = 0;
   int          cycle_count = 0;
   int          checks = 0;
   int          errors = 0;

   pipeline_top dut (
      .i_clock           (i_clock),
      .i_reset           (reset),
      .i_frame_from_host (frame_from_host),
      .o_frame_to_host   (frame_to_host),
      .o_frame_valid     (frame_valid),
      .o_end_of_data     (end_of_data),
      .o_halted          (halted)
   );

   always #10 i_clock = ~i_clock;

   always @(posedge i_clock) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Test failures found");
         $finish;
      end
   end

   // Output frames are collected mid-cycle
   always @(negedge i_clock) begin
      if (end_of_data) begin
         eod_count++;
         if (!valid_prev || frame_valid) begin
            errors++;
            $display("Error at %0t: end of data did not follow the last frame", $time);
         end
      end
      if (frame_valid) begin
         frames.push_back(frame_to_host);
      end
      valid_prev = frame_valid;
   end

   function automatic logic [31:0] lcg_step(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic check_equal(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
      end
   endtask

   task automatic send_command(input logic [NB_FRAME-1:0] frame);
      @(posedge i_clock);
      #1;
      frame_from_host = frame;
      @(posedge i_clock);
      #1;
      frame_from_host = '0;
   endtask

   function automatic logic [31:0] encode(input int kind, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd,
                                          input logic [15:0] imm);
      case (kind)
         0:       return {OP_RTYPE, rs, rt, rd, 5'b0, FN_ADDU};
         1:       return {OP_RTYPE, rs, rt, rd, 5'b0, FN_SUBU};
         2:       return {OP_RTYPE, rs, rt, rd, 5'b0, FN_AND};
         3:       return {OP_RTYPE, rs, rt, rd, 5'b0, FN_OR};
         4:       return {OP_RTYPE, rs, rt, rd, 5'b0, FN_XOR};
         5:       return {OP_RTYPE, rs, rt, rd, 5'b0, FN_SLT};
         6:       return {OP_ADDIU, rs, rt, imm};
         7:       return {OP_ANDI, rs, rt, imm};
         default: return {OP_ORI, rs, rt, imm};
      endcase
   endfunction

   // Sequential ISA model, r0 stays zero
   task automatic model_execute(input logic [31:0] instr);
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] result;
      logic [4:0]  dest;
      logic        write;
      a      = model_regs[instr[25:21]];
      b      = model_regs[instr[20:16]];
      dest   = instr[20:16];
      write  = 1'b1;
      result = '0;
      case (instr[31:26])
         OP_RTYPE: begin
            dest = instr[15:11];
            case (instr[5:0])
               FN_ADDU: result = a + b;
               FN_SUBU: result = a - b;
               FN_AND:  result = a & b;
               FN_OR:   result = a | b;
               FN_XOR:  result = a ^ b;
               FN_SLT:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
               default: write = 1'b0;
            endcase
         end
         OP_ADDIU: result = a + {{16{instr[15]}}, instr[15:0]};
         OP_ANDI:  result = a & {16'b0, instr[15:0]};
         OP_ORI:   result = a | {16'b0, instr[15:0]};
         default:  write = 1'b0;
      endcase
      if (write && dest != 5'd0) begin
         model_regs[dest] = result;
      end
   endtask

   // First nine words cover every ALU operation, word 4 targets r0
   task automatic load_program();
      logic [31:0] instr;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [4:0]  rd;
      logic [15:0] imm;
      int          kind;
      for (int i = 0; i <= PROG_LEN; i++) begin
         rand_state = lcg_step(rand_state);
         rs = {3'b0, rand_state[31:30]};
         rt = {3'b0, rand_state[29:28]};
         rd = (i == 4) ? 5'd0 : {3'b0, rand_state[27:26]};
         rand_state = lcg_step(rand_state);
         imm = rand_state[31:16];
         rand_state = lcg_step(rand_state);
         kind = (i < 9) ? i : int'(rand_state[31:16] % 16'd9);
         if (i == PROG_LEN) begin
            instr = HALT_WORD;
         end else begin
            instr = encode(kind, rs, rt, rd, imm);
            model_execute(instr);
         end
         send_command({CMD_INSTR_LOW, 10'b0, instr[15:0]});
         send_command({CMD_INSTR_HIGH, 4'b0, 6'(i), instr[31:16]});
      end
   endtask

   task automatic run_until_halt();
      send_command({CMD_RUN, 26'b0});
      while (!halted) @(negedge i_clock);
      // Older instructions have written the registers two cycles on
      repeat (2) @(posedge i_clock);
   endtask

   task automatic readout(input logic [NB_CMD-1:0] reader, input bit overlap_request);
      int eod_start;
      frames.delete();
      eod_start = eod_count;
      send_command({CMD_READ, 20'b0, reader});
      if (overlap_request) begin
         while (frames.size() < 3) @(negedge i_clock);
         send_command({CMD_READ, 20'b0, READER_WB_STATE});
      end
      while (eod_count == eod_start) @(negedge i_clock);
      // A stray readout would start within this window
      repeat (6) @(posedge i_clock);
      check_equal("o_end_of_data pulses", eod_count - eod_start, 1);
   endtask

   task automatic check_registers();
      check_equal("register frame count", frames.size(), REGFILE_DEPTH);
      for (int i = 0; i < REGFILE_DEPTH && i < frames.size(); i++) begin
         check_equal($sformatf("o_frame_to_host[r%0d]", i), frames[i], model_regs[i]);
      end
   endtask

   initial begin
      i_clock = 1'b0;
      reset = 1'b1;
      frame_from_host = '0;
      for (int i = 0; i < 32; i++) begin
         model_regs[i] = '0;
      end
      repeat (3) @(posedge i_clock);
      #1;
      reset = 1'b0;
      @(negedge i_clock);
      check_equal("o_halted", 32'(halted), 0);
      check_equal("o_frame_valid", 32'(frame_valid), 0);
      check_equal("o_end_of_data", 32'(end_of_data), 0);
      readout(READER_REGFILE, 1'b0);
      check_registers();

      load_program();
      run_until_halt();
      readout(READER_REGFILE, 1'b0);
      check_registers();

      readout(READER_FETCH_STATE, 1'b0);
      check_equal("fetch frame count", frames.size(), 2);
      if (frames.size() == 2) begin
         check_equal("fetch frame 0 (instruction)", frames[0], HALT_WORD);
         check_equal("fetch frame 1 (address)", frames[1], PROG_LEN);
      end
      readout(READER_WB_STATE, 1'b0);
      check_equal("writeback frame count", frames.size(), 2);
      if (frames.size() == 2) begin
         check_equal("writeback frame 0", frames[0], 0);
         check_equal("writeback frame 1", frames[1], 0);
      end

      send_command({CMD_SOFT_RESET, 26'b0});
      for (int i = 0; i < 32; i++) begin
         model_regs[i] = '0;
      end
      @(negedge i_clock);
      check_equal("o_halted", 32'(halted), 0);
      readout(READER_REGFILE, 1'b0);
      check_registers();

      load_program();
      run_until_halt();
      readout(READER_REGFILE, 1'b1);
      check_registers();

      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule
